// ==== common/vic_pkg.sv ====
package vic_pkg;

   localparam int VRAM_AW = 12;  // 4 KiB video RAM
   localparam int VRAM_DW = 8;

   typedef logic [VRAM_AW-1:0] vram_addr_t;
   typedef logic [VRAM_DW-1:0] vram_data_t;
   typedef logic [3:0]         color_t;      // palette index
   typedef logic [3:0]         reg_addr_t;   // word index on the register port

   // register map, one byte per index
   localparam reg_addr_t REG_RASTER_CMP  = 4'h0;  // compare line for the raster irq
   localparam reg_addr_t REG_IRQ_STATUS  = 4'h1;  // bit 0 raster hit, write 1 to clear
   localparam reg_addr_t REG_IRQ_ENABLE  = 4'h2;  // bit 0 raster irq enable
   localparam reg_addr_t REG_BORDER      = 4'h3;
   localparam reg_addr_t REG_BACKGROUND  = 4'h4;
   localparam reg_addr_t REG_FOREGROUND  = 4'h5;
   localparam reg_addr_t REG_SCREEN_BASE = 4'h6;  // address bits 11:4 of the screen
   localparam reg_addr_t REG_CHAR_BASE   = 4'h7;  // address bits 11:4 of the glyphs

   // display setup, registers to fetcher
   typedef struct packed {
      color_t     border;
      color_t     background;
      color_t     foreground;
      vram_addr_t screen_base;  // 16-byte aligned
      vram_addr_t char_base;    // 16-byte aligned
   } disp_cfg_t;

   // beam position, raster timer to fetcher
   typedef struct packed {
      logic [7:0] x;
      logic [7:0] y;
      logic       hsync;
      logic       vsync;
      logic       fetch;  // one cell ahead of the active window
   } raster_pos_t;

endpackage

// ==== common/vram_bus_if.sv ====
`timescale 1ns/100ps

// request/grant port into the shared video RAM
// a master keeps req and its fields steady until gnt
// read data follows one cycle after the grant, a write completes in the grant cycle
interface vram_bus_if;

   logic                req;
   logic                we;
   vic_pkg::vram_addr_t addr;
   vic_pkg::vram_data_t wdata;
   logic                gnt;
   vic_pkg::vram_data_t rdata;

   modport master (
      output req,
      output we,
      output addr,
      output wdata,
      input  gnt,
      input  rdata
   );

   modport slave (
      input  req,
      input  we,
      input  addr,
      input  wdata,
      output gnt,
      output rdata
   );

endinterface

// ==== compile.f ====
common/vic_pkg.sv
common/vram_bus_if.sv
src/vram_arbiter.sv
src/video_ram.sv
src/vic_regs.sv
src/cpu_vram_port.sv
raster/raster_timer.sv
raster/char_fetcher.sv
src/vic_top.sv
verification/vic_tb.sv

// ==== raster/char_fetcher.sv ====
`timescale 1ns/100ps

module char_fetcher #(
   parameter int COLS = 8,
   parameter int ROWS = 4
) (
   input  logic                 sys_clock,
   input  logic                 rst,
   input  vic_pkg::raster_pos_t pos,
   input  vic_pkg::disp_cfg_t   disp_cfg,
   vram_bus_if.master           bus,
   output vic_pkg::color_t      pixel,
   output logic                 active,
   output logic                 hsync,
   output logic                 vsync
);

   localparam int LINE_W = $clog2(ROWS * 8);  // pixel line inside the text area
   localparam int PIPE_N = 7;                 // output register makes it 8 cycles
   localparam logic [7:0] COL_LAST = 8'(COLS - 1);

   logic [2:0]          phase;
   logic [7:0]          col_cnt;
   logic [LINE_W-1:0]   line_cnt;
   logic                rd_pend;      // a granted read returns this cycle
   logic                sh_valid;     // shifter holds a visible cell
   vic_pkg::vram_data_t code;
   vic_pkg::vram_data_t glyph_next;
   vic_pkg::vram_data_t shifter;
   vic_pkg::vram_addr_t screen_addr;
   vic_pkg::vram_addr_t glyph_addr;
   vic_pkg::color_t     color_raw;
   logic [6:0]          pipe [PIPE_N];  // {active, hsync, vsync, colour}

   assign phase = pos.x[2:0];  // cell slots line up with x

   assign screen_addr = disp_cfg.screen_base
                      + vic_pkg::vram_addr_t'(line_cnt[LINE_W-1:3] * COLS)
                      + vic_pkg::vram_addr_t'(col_cnt);
   assign glyph_addr  = disp_cfg.char_base
                      + vic_pkg::vram_addr_t'({code, 3'b000})
                      + vic_pkg::vram_addr_t'(line_cnt[2:0]);

   // slot 0 screen code, slot 2 glyph byte, all reads
   assign bus.req   = pos.fetch && (phase == 3'd0 || phase == 3'd2);
   assign bus.we    = 1'b0;
   assign bus.addr  = (phase == 3'd0) ? screen_addr : glyph_addr;
   assign bus.wdata = '0;

   always_ff @(posedge sys_clock) begin
      if (rst) begin
         col_cnt  <= '0;
         line_cnt <= '0;
         rd_pend  <= 1'b0;
         sh_valid <= 1'b0;
      end else begin
         rd_pend <= bus.gnt;
         if (pos.vsync) begin
            line_cnt <= '0;
         end else if (pos.fetch && phase == 3'd7 && col_cnt == COL_LAST) begin
            line_cnt <= line_cnt + 1'b1;  // after the last cell of the line
         end
         if (pos.fetch && phase == 3'd7) begin
            col_cnt <= (col_cnt == COL_LAST) ? '0 : col_cnt + 8'd1;
         end
         if (phase == 3'd7) sh_valid <= pos.fetch;
      end
   end

   // glyph fetched in one slot is shown during the next
   always_ff @(posedge sys_clock) begin
      if (rd_pend && phase == 3'd1) code <= bus.rdata;
      if (rd_pend && phase == 3'd3) glyph_next <= bus.rdata;
      if (phase == 3'd7) begin
         shifter <= glyph_next;
      end else begin
         shifter <= {shifter[6:0], 1'b0};  // msb is the leftmost pixel
      end
   end

   assign color_raw = shifter[7] ? disp_cfg.foreground : disp_cfg.background;

   // syncs and window ride along with the colour
   always_ff @(posedge sys_clock) begin
      if (rst) begin
         for (int i = 0; i < PIPE_N; i++) begin
            pipe[i] <= '0;
         end
         pixel  <= '0;
         active <= 1'b0;
         hsync  <= 1'b0;
         vsync  <= 1'b0;
      end else begin
         pipe[0] <= {sh_valid, pos.hsync, pos.vsync, color_raw};
         for (int i = 1; i < PIPE_N; i++) begin
            pipe[i] <= pipe[i-1];
         end
         active <= pipe[PIPE_N-1][6];
         hsync  <= pipe[PIPE_N-1][5];
         vsync  <= pipe[PIPE_N-1][4];
         pixel  <= pipe[PIPE_N-1][6] ? pipe[PIPE_N-1][3:0] : disp_cfg.border;
      end
   end

endmodule

// ==== raster/raster_timer.sv ====
`timescale 1ns/100ps

module raster_timer #(
   parameter int H_TOTAL      = 96,
   parameter int V_TOTAL      = 40,
   parameter int COLS         = 8,
   parameter int ROWS         = 4,
   parameter int H_SYNC_START = 84,
   parameter int V_SYNC_LINE  = 38
) (
   input  logic                 sys_clock,
   input  logic                 rst,
   input  logic [7:0]           raster_cmp,
   output logic                 raster_hit,
   output vic_pkg::raster_pos_t pos
);

   localparam int H_ACT    = 16;  // first visible column, kept a multiple of 8
   localparam int V_ACT    = 4;   // first visible line
   localparam int H_SYNC_W = 8;

   localparam logic [7:0] X_LAST      = 8'(H_TOTAL - 1);
   localparam logic [7:0] Y_LAST      = 8'(V_TOTAL - 1);
   localparam logic [7:0] FETCH_FIRST = 8'(H_ACT - 8);  // one cell ahead of the pixels
   localparam logic [7:0] FETCH_END   = 8'(H_ACT - 8 + COLS * 8);
   localparam logic [7:0] V_FIRST     = 8'(V_ACT);
   localparam logic [7:0] V_END       = 8'(V_ACT + ROWS * 8);
   localparam logic [7:0] HS_FIRST    = 8'(H_SYNC_START);
   localparam logic [7:0] HS_END      = 8'(H_SYNC_START + H_SYNC_W);
   localparam logic [7:0] VS_LINE     = 8'(V_SYNC_LINE);

   logic [7:0] x_cnt;
   logic [7:0] y_cnt;
   logic       h_fetch;
   logic       v_active;

   // one pixel per clock
   always_ff @(posedge sys_clock) begin
      if (rst) begin
         x_cnt <= '0;
         y_cnt <= '0;
      end else if (x_cnt == X_LAST) begin
         x_cnt <= '0;
         y_cnt <= (y_cnt == Y_LAST) ? '0 : y_cnt + 8'd1;  // frame wrap
      end else begin
         x_cnt <= x_cnt + 8'd1;
      end
   end

   assign h_fetch  = x_cnt >= FETCH_FIRST && x_cnt < FETCH_END;
   assign v_active = y_cnt >= V_FIRST && y_cnt < V_END;

   assign pos.x     = x_cnt;
   assign pos.y     = y_cnt;
   assign pos.hsync = x_cnt >= HS_FIRST && x_cnt < HS_END;
   assign pos.vsync = y_cnt == VS_LINE;  // whole line wide
   assign pos.fetch = h_fetch && v_active;

   // single cycle, at the left edge of the compare line
   assign raster_hit = x_cnt == 8'd0 && y_cnt == raster_cmp;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module vic_tb -f compile.f -o vic_sim
out=$(./obj_dir/vic_sim)
echo "$out"
echo "$out" | grep -q "^Done: no errors$"

// ==== src/cpu_vram_port.sv ====
`timescale 1ns/100ps

module cpu_vram_port (
   input  logic                sys_clock,
   input  logic                rst,
   input  logic                psel_vram,
   input  logic                penable,
   input  logic                pwrite,
   input  vic_pkg::vram_addr_t paddr_vram,
   input  vic_pkg::vram_data_t pwdata,
   output vic_pkg::vram_data_t prdata_vram,
   output logic                pready_vram,
   vram_bus_if.master          bus
);

   typedef enum logic [1:0] {IDLE, REQ, WAIT_DATA, DONE} state_t;

   state_t state;
   state_t state_nxt;
   logic   access;

   assign access = psel_vram && penable;

   // request straight from the access phase, apb holds the fields for us
   assign bus.req   = access && (state == IDLE || state == REQ);
   assign bus.we    = pwrite;
   assign bus.addr  = paddr_vram;
   assign bus.wdata = pwdata;

   assign pready_vram = (state == DONE);  // stretched until the ram is done

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE, REQ: begin
            if (bus.gnt) begin
               state_nxt = pwrite ? DONE : WAIT_DATA;
            end else if (access) begin
               state_nxt = REQ;  // fetcher owns this cycle
            end
         end
         WAIT_DATA: state_nxt = DONE;
         DONE:      state_nxt = IDLE;
         default:   state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge sys_clock) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge sys_clock) begin
      if (state == WAIT_DATA) prdata_vram <= bus.rdata;  // byte from the arbiter
   end

   a_req_held: assert property (@(posedge sys_clock) disable iff (rst)
      bus.req && !bus.gnt |=> bus.req && $stable(bus.addr) && $stable(bus.we))
      else $error("cpu request dropped or changed before grant");

endmodule

// ==== src/vic_regs.sv ====
`timescale 1ns/100ps

module vic_regs (
   input  logic                sys_clock,
   input  logic                rst,
   input  logic                psel_reg,
   input  logic                penable,
   input  logic                pwrite,
   input  vic_pkg::reg_addr_t  paddr_reg,
   input  vic_pkg::vram_data_t pwdata,
   output vic_pkg::vram_data_t prdata_reg,
   output logic                pready_reg,
   input  logic                raster_hit,
   output logic                irq,
   output vic_pkg::disp_cfg_t  disp_cfg,
   output logic [7:0]          raster_cmp
);

   logic            wr_en;
   logic            status_clr;
   logic            irq_status;
   logic            irq_enable;
   vic_pkg::color_t border_r;
   vic_pkg::color_t background_r;
   vic_pkg::color_t foreground_r;
   logic [7:0]      screen_base_r;  // upper address bits
   logic [7:0]      char_base_r;

   assign pready_reg = psel_reg && penable;  // no wait states
   assign wr_en      = pready_reg && pwrite;
   assign status_clr = wr_en && paddr_reg == vic_pkg::REG_IRQ_STATUS && pwdata[0];

   always_ff @(posedge sys_clock) begin
      if (rst) begin
         raster_cmp    <= '0;
         irq_enable    <= 1'b0;
         border_r      <= '0;
         background_r  <= '0;
         foreground_r  <= '0;
         screen_base_r <= '0;
         char_base_r   <= '0;
      end else if (wr_en) begin
         case (paddr_reg)
            vic_pkg::REG_RASTER_CMP:  raster_cmp    <= pwdata;
            vic_pkg::REG_IRQ_ENABLE:  irq_enable    <= pwdata[0];
            vic_pkg::REG_BORDER:      border_r      <= pwdata[3:0];
            vic_pkg::REG_BACKGROUND:  background_r  <= pwdata[3:0];
            vic_pkg::REG_FOREGROUND:  foreground_r  <= pwdata[3:0];
            vic_pkg::REG_SCREEN_BASE: screen_base_r <= pwdata;
            vic_pkg::REG_CHAR_BASE:   char_base_r   <= pwdata;
            default: ;  // status is handled below, rest ignored
         endcase
      end
   end

   // raster hit wins over a clear in the same cycle
   always_ff @(posedge sys_clock) begin
      if (rst) begin
         irq_status <= 1'b0;
         irq        <= 1'b0;
      end else begin
         irq_status <= raster_hit || (irq_status && !status_clr);
         irq        <= irq_status && irq_enable;
      end
   end

   always_comb begin
      prdata_reg = '0;  // holes read as zero
      case (paddr_reg)
         vic_pkg::REG_RASTER_CMP:  prdata_reg = raster_cmp;
         vic_pkg::REG_IRQ_STATUS:  prdata_reg = {7'd0, irq_status};
         vic_pkg::REG_IRQ_ENABLE:  prdata_reg = {7'd0, irq_enable};
         vic_pkg::REG_BORDER:      prdata_reg = {4'd0, border_r};
         vic_pkg::REG_BACKGROUND:  prdata_reg = {4'd0, background_r};
         vic_pkg::REG_FOREGROUND:  prdata_reg = {4'd0, foreground_r};
         vic_pkg::REG_SCREEN_BASE: prdata_reg = screen_base_r;
         vic_pkg::REG_CHAR_BASE:   prdata_reg = char_base_r;
         default: ;
      endcase
   end

   assign disp_cfg.border      = border_r;
   assign disp_cfg.background  = background_r;
   assign disp_cfg.foreground  = foreground_r;
   assign disp_cfg.screen_base = {screen_base_r, 4'h0};
   assign disp_cfg.char_base   = {char_base_r, 4'h0};

   // access phase only ever follows a setup phase with psel held
   a_apb_setup: assert property (@(posedge sys_clock) disable iff (rst)
      psel_reg && penable |-> $past(psel_reg && !penable))
      else $error("penable raised on register port without setup phase");

endmodule

// ==== src/vic_top.sv ====
`timescale 1ns/100ps

module vic_top #(
   parameter int H_TOTAL      = 96,
   parameter int V_TOTAL      = 40,
   parameter int COLS         = 8,
   parameter int ROWS         = 4,
   parameter int H_SYNC_START = 84,
   parameter int V_SYNC_LINE  = 38
) (
   input  logic                sys_clock,
   input  logic                rst,
   input  logic                psel_reg,
   input  logic                psel_vram,
   input  logic                penable,
   input  logic                pwrite,
   input  vic_pkg::vram_addr_t paddr,
   input  vic_pkg::vram_data_t pwdata,
   output vic_pkg::vram_data_t prdata_reg,
   output vic_pkg::vram_data_t prdata_vram,
   output logic                pready_reg,
   output logic                pready_vram,
   output logic                irq,
   output vic_pkg::color_t     pixel,
   output logic                active,
   output logic                hsync,
   output logic                vsync
);

   logic                 raster_hit;
   logic [7:0]           raster_cmp;
   vic_pkg::disp_cfg_t   disp_cfg;
   vic_pkg::raster_pos_t pos;
   logic                 ram_en;
   logic                 ram_we;
   vic_pkg::vram_addr_t  ram_addr;
   vic_pkg::vram_data_t  ram_wdata;
   vic_pkg::vram_data_t  ram_rdata;

   vram_bus_if fetch_bus ();
   vram_bus_if cpu_bus ();

   vram_arbiter vram_arbiter_i (
      .sys_clock (sys_clock),
      .rst       (rst),
      .fetch_bus (fetch_bus.slave),
      .cpu_bus   (cpu_bus.slave),
      .ram_en    (ram_en),
      .ram_we    (ram_we),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata),
      .ram_rdata (ram_rdata)
   );

   video_ram video_ram_i (
      .sys_clock (sys_clock),
      .en        (ram_en),
      .we        (ram_we),
      .addr      (ram_addr),
      .wdata     (ram_wdata),
      .rdata     (ram_rdata)
   );

   vic_regs vic_regs_i (
      .sys_clock  (sys_clock),
      .rst        (rst),
      .psel_reg   (psel_reg),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr_reg  (paddr[3:0]),  // register port decodes the low word index
      .pwdata     (pwdata),
      .prdata_reg (prdata_reg),
      .pready_reg (pready_reg),
      .raster_hit (raster_hit),
      .irq        (irq),
      .disp_cfg   (disp_cfg),
      .raster_cmp (raster_cmp)
   );

   cpu_vram_port cpu_vram_port_i (
      .sys_clock   (sys_clock),
      .rst         (rst),
      .psel_vram   (psel_vram),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr_vram  (paddr),
      .pwdata      (pwdata),
      .prdata_vram (prdata_vram),
      .pready_vram (pready_vram),
      .bus         (cpu_bus.master)
   );

   raster_timer #(
      .H_TOTAL      (H_TOTAL),
      .V_TOTAL      (V_TOTAL),
      .COLS         (COLS),
      .ROWS         (ROWS),
      .H_SYNC_START (H_SYNC_START),
      .V_SYNC_LINE  (V_SYNC_LINE)
   ) raster_timer_i (
      .sys_clock  (sys_clock),
      .rst        (rst),
      .raster_cmp (raster_cmp),
      .raster_hit (raster_hit),
      .pos        (pos)
   );

   char_fetcher #(
      .COLS (COLS),
      .ROWS (ROWS)
   ) char_fetcher_i (
      .sys_clock (sys_clock),
      .rst       (rst),
      .pos       (pos),
      .disp_cfg  (disp_cfg),
      .bus       (fetch_bus.master),
      .pixel     (pixel),
      .active    (active),
      .hsync     (hsync),
      .vsync     (vsync)
   );

endmodule

// ==== src/video_ram.sv ====
`timescale 1ns/100ps

module video_ram (
   input  logic                sys_clock,
   input  logic                en,
   input  logic                we,
   input  vic_pkg::vram_addr_t addr,
   input  vic_pkg::vram_data_t wdata,
   output vic_pkg::vram_data_t rdata
);

   localparam int DEPTH = 1 << vic_pkg::VRAM_AW;

   vic_pkg::vram_data_t mem [DEPTH];  // screen codes and glyphs share this

   // single port, read returns one cycle later
   always_ff @(posedge sys_clock) begin
      if (en) begin
         if (we) begin
            mem[addr] <= wdata;
         end else begin
            rdata <= mem[addr];
         end
      end
   end

endmodule

// ==== src/vram_arbiter.sv ====
`timescale 1ns/100ps

module vram_arbiter (
   input  logic                sys_clock,
   input  logic                rst,
   vram_bus_if.slave           fetch_bus,
   vram_bus_if.slave           cpu_bus,
   output logic                ram_en,
   output logic                ram_we,
   output vic_pkg::vram_addr_t ram_addr,
   output vic_pkg::vram_data_t ram_wdata,
   input  vic_pkg::vram_data_t ram_rdata
);

   logic fetch_rd_q;  // returning byte belongs to the fetcher
   logic cpu_rd_q;    // returning byte belongs to the cpu

   // fetcher steals the cycle, cpu only gets the gaps
   assign fetch_bus.gnt = fetch_bus.req;
   assign cpu_bus.gnt   = cpu_bus.req && !fetch_bus.req;

   assign ram_en    = fetch_bus.req || cpu_bus.req;
   assign ram_we    = fetch_bus.req ? fetch_bus.we    : cpu_bus.we;
   assign ram_addr  = fetch_bus.req ? fetch_bus.addr  : cpu_bus.addr;
   assign ram_wdata = fetch_bus.req ? fetch_bus.wdata : cpu_bus.wdata;

   always_ff @(posedge sys_clock) begin
      if (rst) begin
         fetch_rd_q <= 1'b0;
         cpu_rd_q   <= 1'b0;
      end else begin
         fetch_rd_q <= fetch_bus.gnt && !fetch_bus.we;
         cpu_rd_q   <= cpu_bus.gnt && !cpu_bus.we;
      end
   end

   // data only shows up on the port that asked for it
   assign fetch_bus.rdata = fetch_rd_q ? ram_rdata : '0;
   assign cpu_bus.rdata   = cpu_rd_q ? ram_rdata : '0;

   // fetcher takes at most two spaced slots per cell, so a held cpu request gets through quickly
   a_cpu_grant_wait: assert property (@(posedge sys_clock) disable iff (rst)
      cpu_bus.req |-> ##[0:2] cpu_bus.gnt)
      else $error("cpu request starved by the fetcher");

endmodule

// ==== verification/vic_tb.sv ====
`timescale 1ns/100ps

module vic_tb;

   localparam int H_TOTAL     = 96;
   localparam int V_TOTAL     = 40;
   localparam int COLS        = 8;
   localparam int ROWS        = 4;
   localparam int FRAME       = H_TOTAL * V_TOTAL;
   localparam int CYCLE_LIMIT = 5 * FRAME + 2000;  // irq, rendering and framing each span frames
   localparam int CLK_PERIOD  = 20;
   localparam logic [31:0] SEED = 32'h767c_5cab;

   logic                sys_clock = 1'b0;
   logic                rst;
   logic                psel_reg;
   logic                psel_vram;
   logic                penable;
   logic                pwrite;
   vic_pkg::vram_addr_t paddr;
   vic_pkg::vram_data_t pwdata;
   vic_pkg::vram_data_t prdata_reg;
   vic_pkg::vram_data_t prdata_vram;
   logic                pready_reg;
   logic                pready_vram;
   logic                irq;
   vic_pkg::color_t     pixel;
   logic                active;
   logic                hsync;
   logic                vsync;

   int          errors = 0;
   int          cycle = 0;
   logic [7:0]  vram_model [4096];  // last byte the host wrote per address
   logic [11:0] scr_addr;
   logic [11:0] chr_addr;
   logic [3:0]  fg_color;
   logic [3:0]  bg_color;

   vic_top #(
      .H_TOTAL      (H_TOTAL),
      .V_TOTAL      (V_TOTAL),
      .COLS         (COLS),
      .ROWS         (ROWS),
      .H_SYNC_START (84),
      .V_SYNC_LINE  (38)
   ) vic_top_i (
      .sys_clock   (sys_clock),
      .rst         (rst),
      .psel_reg    (psel_reg),
      .psel_vram   (psel_vram),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata_reg  (prdata_reg),
      .prdata_vram (prdata_vram),
      .pready_reg  (pready_reg),
      .pready_vram (pready_vram),
      .irq         (irq),
      .pixel       (pixel),
      .active      (active),
      .hsync       (hsync),
      .vsync       (vsync)
   );

   always #(CLK_PERIOD / 2) sys_clock = ~sys_clock;

   // watchdog, the whole run fits in a few frames
   always @(posedge sys_clock) begin
      cycle <= cycle + 1;
      if (cycle >= CYCLE_LIMIT) begin
         $display("timeout: tests still running after %0d cycles", cycle);
         $display("errors: %0d", errors);
         $display("Done: errors found");
         $finish;
      end
   end

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   // one apb transfer, setup then access until pready
   task automatic apb_access(input logic to_vram, input logic write, input logic [11:0] addr,
                             input logic [7:0] wdata, output logic [7:0] rdata);
      logic done;
      int   n;
      @(negedge sys_clock);
      psel_reg  = !to_vram;
      psel_vram = to_vram;
      pwrite    = write;
      paddr     = addr;
      pwdata    = wdata;
      penable   = 1'b0;
      @(negedge sys_clock);
      penable = 1'b1;
      n       = 0;
      done    = 1'b0;
      while (!done) begin
         #(CLK_PERIOD / 4);  // mid low phase, well clear of the rising edge
         done  = to_vram ? pready_vram : pready_reg;
         rdata = to_vram ? prdata_vram : prdata_reg;
         n++;
         @(negedge sys_clock);
      end
      psel_reg  = 1'b0;
      psel_vram = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      if (to_vram && n > 4) begin  // fetcher may steal at most one slot per try
         errors++;
         $display("vram access at %03h took %0d access cycles, more than 4", addr, n);
      end
   endtask

   task automatic reg_write(input logic [3:0] idx, input logic [7:0] data);
      logic [7:0] ignored;
      apb_access(1'b0, 1'b1, {8'h00, idx}, data, ignored);
   endtask

   task automatic reg_read(input logic [3:0] idx, output logic [7:0] data);
      apb_access(1'b0, 1'b0, {8'h00, idx}, 8'h00, data);
   endtask

   task automatic vram_write(input logic [11:0] addr, input logic [7:0] data);
      logic [7:0] ignored;
      apb_access(1'b1, 1'b1, addr, data, ignored);
      vram_model[addr] = data;
   endtask

   task automatic vram_read(input logic [11:0] addr, output logic [7:0] data);
      apb_access(1'b1, 1'b0, addr, 8'h00, data);
   endtask

   task automatic wait_vsync_rise;
      @(negedge sys_clock);
      while (vsync) @(negedge sys_clock);
      while (!vsync) @(negedge sys_clock);
   endtask

   task automatic wait_irq_high;
      @(negedge sys_clock);
      while (!irq) @(negedge sys_clock);
   endtask

   // colour of text pixel k on text line `line`, straight from the cell rule
   function automatic logic [3:0] expected_pixel(input int line, input int k);
      logic [11:0] code_addr;
      logic [11:0] glyph_addr;
      logic [7:0]  glyph;
      code_addr  = scr_addr + 12'(line / 8 * COLS + k / 8);
      glyph_addr = chr_addr + 12'(vram_model[code_addr] * 8 + line % 8);
      glyph      = vram_model[glyph_addr];
      return glyph[7 - k % 8] ? fg_color : bg_color;  // msb leftmost
   endfunction

   task automatic register_round_trip;
      logic [3:0] idx [6];
      logic [7:0] wval [6];
      logic [7:0] rval;
      int         i;
      idx = '{vic_pkg::REG_RASTER_CMP, vic_pkg::REG_BORDER, vic_pkg::REG_BACKGROUND,
              vic_pkg::REG_FOREGROUND, vic_pkg::REG_SCREEN_BASE, vic_pkg::REG_CHAR_BASE};
      for (i = 0; i < 6; i++) begin
         wval[i] = 8'($urandom);
         if (i >= 1 && i <= 3) wval[i] = wval[i] & 8'h0f;  // colour registers are 4 bits
         reg_write(idx[i], wval[i]);
      end
      for (i = 0; i < 6; i++) begin
         reg_read(idx[i], rval);
         compare($sformatf("prdata_reg[%0h]", idx[i]), rval, wval[i]);
      end
      reg_read(4'(8 + $urandom % 8), rval);  // upper half of the map is empty
      compare("prdata_reg hole", rval, 8'h00);
   endtask

   task automatic vram_round_trip;
      logic [11:0] addr [32];
      logic [7:0]  rval;
      int          i;
      while (!active) @(negedge sys_clock);  // fetcher busy, cpu has to wait for slots
      for (i = 0; i < 32; i++) begin
         addr[i] = 12'($urandom);
         vram_write(addr[i], 8'($urandom));
      end
      for (i = 0; i < 32; i++) begin
         vram_read(addr[i], rval);
         compare($sformatf("prdata_vram[%03h]", addr[i]), rval, vram_model[addr[i]]);
      end
   endtask

   task automatic raster_interrupt;
      logic [7:0] rval;
      int         t_first;
      int         t_second;
      reg_write(vic_pkg::REG_RASTER_CMP, 8'd10);
      reg_write(vic_pkg::REG_IRQ_STATUS, 8'h01);  // drop a hit from the old compare line
      reg_write(vic_pkg::REG_IRQ_ENABLE, 8'h01);
      wait_irq_high();
      t_first = cycle;
      reg_write(vic_pkg::REG_IRQ_STATUS, 8'h01);
      @(negedge sys_clock);  // irq trails status by a cycle
      compare("irq after clear", irq, 1'b0);
      wait_irq_high();
      t_second = cycle;
      compare("irq period", t_second - t_first, FRAME);
      reg_write(vic_pkg::REG_IRQ_STATUS, 8'h01);
      reg_write(vic_pkg::REG_IRQ_ENABLE, 8'h00);
      // next hit lands one frame on, masked
      while (cycle < t_second + FRAME + 4) begin
         @(negedge sys_clock);
         compare("irq while masked", irq, 1'b0);
      end
      reg_read(vic_pkg::REG_IRQ_STATUS, rval);
      compare("irq status while masked", rval, 8'h01);
      reg_write(vic_pkg::REG_IRQ_STATUS, 8'h01);
   endtask

   task automatic character_rendering;
      int line;
      int k;
      int i;
      scr_addr = 12'h100;
      chr_addr = 12'h400;
      for (i = 0; i < COLS * ROWS; i++) begin
         vram_write(scr_addr + 12'(i), 8'($urandom % 16));  // codes index a 16 glyph table
      end
      for (i = 0; i < 16 * 8; i++) begin
         vram_write(chr_addr + 12'(i), 8'($urandom));
      end
      fg_color = 4'($urandom);
      bg_color = fg_color + 4'(1 + $urandom % 15);  // never the same as fg
      reg_write(vic_pkg::REG_SCREEN_BASE, scr_addr[11:4]);
      reg_write(vic_pkg::REG_CHAR_BASE, chr_addr[11:4]);
      reg_write(vic_pkg::REG_FOREGROUND, {4'h0, fg_color});
      reg_write(vic_pkg::REG_BACKGROUND, {4'h0, bg_color});
      wait_vsync_rise();  // next frame is fetched with the new setup
      for (line = 0; line < ROWS * 8; line++) begin
         while (!active) @(negedge sys_clock);
         for (k = 0; k < COLS * 8; k++) begin
            compare($sformatf("pixel line %0d col %0d", line, k), pixel,
                    expected_pixel(line, k));
            @(negedge sys_clock);
         end
      end
   endtask

   task automatic border_colour;
      logic [3:0] border;
      border = 4'($urandom);
      reg_write(vic_pkg::REG_BORDER, {4'h0, border});
      @(negedge sys_clock);  // output register catches up
      repeat (FRAME) begin
         if (!active) compare("pixel in border", pixel, border);
         @(negedge sys_clock);
      end
   endtask

   task automatic sync_framing;
      int   len;
      int   hs_count;
      int   hs_last;
      int   px_count;
      int   lines;
      logic hs_q;
      logic act_q;
      logic vs_q;
      logic vs_rise;
      wait_vsync_rise();
      len      = 0;
      hs_count = 0;
      hs_last  = -1;
      px_count = 0;
      lines    = 0;
      hs_q     = hsync;
      act_q    = active;
      vs_q     = vsync;
      vs_rise  = 1'b0;
      while (!vs_rise) begin  // one frame, vsync rise to vsync rise
         @(negedge sys_clock);
         len++;
         if (hsync && !hs_q) begin
            if (hs_last >= 0) compare("hsync period", len - hs_last, H_TOTAL);
            hs_last = len;
            hs_count++;
         end
         if (active) px_count++;
         if (!active && act_q) begin
            compare("active pixels per line", px_count, COLS * 8);
            px_count = 0;
            lines++;
         end
         vs_rise = vsync && !vs_q;
         hs_q    = hsync;
         act_q   = active;
         vs_q    = vsync;
      end
      compare("vsync period", len, FRAME);
      compare("hsync pulses per frame", hs_count, V_TOTAL);
      compare("active lines per frame", lines, ROWS * 8);
   endtask

   initial begin
      void'($urandom(SEED));
      rst       = 1'b1;
      psel_reg  = 1'b0;
      psel_vram = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      repeat (4) @(negedge sys_clock);
      rst = 1'b0;
      register_round_trip();
      vram_round_trip();
      raster_interrupt();
      character_rendering();
      fork  // both watch the same frame
         border_colour();
         sync_framing();
      join
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule
